// ==== hw/gcn_dims_pkg.sv ====
`default_nettype none

package gcn_dims_pkg;

    ////////////////////////////////
    // layer sizes
    ////////////////////////////////
    localparam int NUM_NODES   = 6;
    localparam int NUM_EDGES   = 6;
    localparam int NUM_FEATS   = 8;
    localparam int NUM_CLASSES = 3;

    // unsigned datapath widths
    localparam int FEAT_W = 5;
    localparam int WGT_W  = 5;
    // six features summed
    localparam int AGG_W  = 8;
    // eight products of agg x weight
    localparam int ACC_W  = 16;

    // cycles spent in each phase
    localparam int ADJ_STEPS    = 6;
    localparam int READ_STEPS   = NUM_FEATS;
    localparam int DRAIN_STEPS  = 2;
    localparam int ARGMAX_STEPS = NUM_CLASSES;

    ////////////////////////////////
    // scalar types
    ////////////////////////////////
    // node number 1..6, zero marks an empty edge slot
    typedef logic [2:0]        node_id_t;
    typedef logic [2:0]        feat_addr_t;
    typedef logic [1:0]        class_t;
    typedef logic [2:0]        step_t;
    typedef logic [FEAT_W-1:0] feat_t;
    typedef logic [WGT_W-1:0]  wgt_t;
    typedef logic [AGG_W-1:0]  agg_t;
    typedef logic [ACC_W-1:0]  acc_t;

    // controller phases in run order
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_ADJ,
        PH_READ,
        PH_DRAIN,
        PH_ARGMAX,
        PH_DONE
    } phase_t;

endpackage

`default_nettype wire

// ==== hw/gcn_bus_pkg.sv ====
`default_nettype none

package gcn_bus_pkg;

    import gcn_dims_pkg::*;

    ////////////////////////////////
    // graph input
    ////////////////////////////////
    // one undirected edge, order of the ends does not matter
    typedef struct packed {
        node_id_t src;
        node_id_t dst;
    } edge_t;

    // coordinate list, slot 0 in the low bits
    typedef struct packed {
        edge_t [NUM_EDGES-1:0] slot;
    } coo_t;

    // neighbour masks, nbr[n] belongs to node n+1
    // bit m of a mask marks node m+1 as neighbour
    typedef struct packed {
        logic [NUM_NODES-1:0][NUM_NODES-1:0] nbr;
    } adj_mat_t;

    ////////////////////////////////
    // memory data
    ////////////////////////////////
    // feature index k of every node
    typedef struct packed {
        feat_t [NUM_NODES-1:0] feat;
    } feat_col_t;

    // weight row k, one entry per class
    typedef struct packed {
        wgt_t [NUM_CLASSES-1:0] wgt;
    } wgt_row_t;

    // aggregated column with the weight row that goes with it
    typedef struct packed {
        logic                 valid;
        agg_t [NUM_NODES-1:0] agg;
        wgt_row_t             wgt;
    } agg_beat_t;

    ////////////////////////////////
    // results
    ////////////////////////////////
    typedef struct packed {
        acc_t [NUM_NODES-1:0][NUM_CLASSES-1:0] acc;
    } acc_mat_t;

    typedef struct packed {
        class_t [NUM_NODES-1:0] label;
    } label_vec_t;

endpackage

`default_nettype wire

// ==== hw/gcn_ctrl_fsm.sv ====
`default_nettype none

module gcn_ctrl_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  last,
    output gcn_dims_pkg::phase_t  phase,
    output logic                  load,
    output logic                  rd_en,
    output logic                  done
);

    import gcn_dims_pkg::*;

    phase_t state_q;
    phase_t state_d;
    // start only counts while no run is in flight
    logic   accept;

    assign accept = start && ((state_q == PH_IDLE) || (state_q == PH_DONE));

    ////////////////////////////////
    // next phase
    ////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            // a fresh start also restarts from done
            PH_IDLE, PH_DONE: begin
                if (accept) begin
                    state_d = PH_ADJ;
                end
            end
            // one edge slot per cycle
            PH_ADJ: begin
                if (last) begin
                    state_d = PH_READ;
                end
            end
            // one feature index per cycle
            PH_READ: begin
                if (last) begin
                    state_d = PH_DRAIN;
                end
            end
            // memory and beat pipeline empties into the mac
            PH_DRAIN: begin
                if (last) begin
                    state_d = PH_ARGMAX;
                end
            end
            // one class per cycle
            PH_ARGMAX: begin
                if (last) begin
                    state_d = PH_DONE;
                end
            end
            default: begin
                state_d = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////
    // outputs
    ////////////////////////////////
    assign phase = state_q;
    // same cycle as the accepted start, clears the datapath
    assign load  = accept;
    // strobe and level come straight off the state register
    assign rd_en = (state_q == PH_READ);
    assign done  = (state_q == PH_DONE);

endmodule

`default_nettype wire

// ==== hw/gcn_step_timer.sv ====
`default_nettype none

module gcn_step_timer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  gcn_dims_pkg::phase_t  phase,
    output gcn_dims_pkg::step_t   step,
    output logic                  last
);

    import gcn_dims_pkg::*;

    phase_t prev_q;
    step_t  cnt_q;
    logic   changed;

    // first cycle of a new phase reads as step 0
    assign changed = (phase != prev_q);
    assign step    = changed ? '0 : cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_q <= PH_IDLE;
            cnt_q  <= '0;
        end else begin
            prev_q <= phase;
            cnt_q  <= step + step_t'(1);
        end
    end

    // final step of each timed phase
    always_comb begin
        case (phase)
            PH_ADJ:    last = (step == step_t'(ADJ_STEPS - 1));
            PH_READ:   last = (step == step_t'(READ_STEPS - 1));
            PH_DRAIN:  last = (step == step_t'(DRAIN_STEPS - 1));
            PH_ARGMAX: last = (step == step_t'(ARGMAX_STEPS - 1));
            // idle and done wait for start instead
            default:   last = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/gcn_adj_builder.sv ====
`default_nettype none

module gcn_adj_builder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  gcn_bus_pkg::coo_t        coo,
    input  gcn_dims_pkg::phase_t     phase,
    input  gcn_dims_pkg::step_t      step,
    output gcn_bus_pkg::adj_mat_t    adj
);

    import gcn_dims_pkg::*;
    import gcn_bus_pkg::*;

    coo_t     coo_q;
    edge_t    cur_edge;
    node_id_t src_idx;
    node_id_t dst_idx;
    logic     edge_ok;

    ////////////////////////////////
    // edge list capture
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (load) begin
            coo_q <= coo;
        end
    end

    // slot under the step counter
    assign cur_edge = coo_q.slot[step];
    // zero at either end is an empty slot
    assign edge_ok  = (cur_edge.src != '0) && (cur_edge.dst != '0);
    // node numbers start at 1, mask bits at 0
    assign src_idx  = cur_edge.src - node_id_t'(1);
    assign dst_idx  = cur_edge.dst - node_id_t'(1);

    ////////////////////////////////
    // symmetric matrix
    ////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj <= '0;
        end else if (load) begin
            adj <= '0;
        end else if ((phase == PH_ADJ) && edge_ok) begin
            // OR keeps duplicates idempotent
            // a self loop hits the same diagonal bit twice
            adj.nbr[src_idx][dst_idx] <= 1'b1;
            adj.nbr[dst_idx][src_idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/gcn_aggregator.sv ====
`default_nettype none

module gcn_aggregator (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd_en,
    input  gcn_bus_pkg::feat_col_t   feat_col,
    input  gcn_bus_pkg::wgt_row_t    wgt_row,
    input  gcn_bus_pkg::adj_mat_t    adj,
    output gcn_bus_pkg::agg_beat_t   beat
);

    import gcn_dims_pkg::*;
    import gcn_bus_pkg::*;

    // memories answer one cycle after the strobe
    logic                 rd_en_q;
    logic                 valid_q;
    agg_t [NUM_NODES-1:0] sum_c;
    agg_t [NUM_NODES-1:0] agg_q;
    wgt_row_t             wgt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            rd_en_q <= rd_en;
            valid_q <= rd_en_q;
        end
    end

    ////////////////////////////////
    // neighbour sum per node
    ////////////////////////////////
    always_comb begin
        for (int n = 0; n < NUM_NODES; n++) begin
            sum_c[n] = '0;
            for (int m = 0; m < NUM_NODES; m++) begin
                if (adj.nbr[n][m]) begin
                    sum_c[n] = sum_c[n] + agg_t'(feat_col.feat[m]);
                end
            end
        end
    end

    // weight row is registered alongside so the mac sees matched pairs
    always_ff @(posedge clk) begin
        if (rd_en_q) begin
            agg_q <= sum_c;
            wgt_q <= wgt_row;
        end
    end

    assign beat.valid = valid_q;
    assign beat.agg   = agg_q;
    assign beat.wgt   = wgt_q;

endmodule

`default_nettype wire

// ==== hw/gcn_transform_mac.sv ====
`default_nettype none

module gcn_transform_mac (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  gcn_bus_pkg::agg_beat_t   beat,
    output gcn_bus_pkg::acc_mat_t    acc
);

    import gcn_dims_pkg::*;

    ////////////////////////////////
    // node x class accumulators
    ////////////////////////////////
    // one beat per feature index, eight beats per run
    // each beat adds agg[node] * wgt[class] everywhere at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (load) begin
            // new graph, drop the previous sums
            acc <= '0;
        end else if (beat.valid) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                for (int c = 0; c < NUM_CLASSES; c++) begin
                    // 13-bit product widened to the accumulator
                    acc.acc[n][c] <= acc.acc[n][c]
                                   + acc_t'(beat.agg[n]) * acc_t'(beat.wgt.wgt[c]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/gcn_argmax.sv ====
`default_nettype none

module gcn_argmax (
    input  logic                     clk,
    input  logic                     rst_n,
    input  gcn_dims_pkg::phase_t     phase,
    input  gcn_dims_pkg::step_t      step,
    input  gcn_bus_pkg::acc_mat_t    acc,
    output gcn_bus_pkg::label_vec_t  y
);

    import gcn_dims_pkg::*;

    // running maximum per node
    acc_t [NUM_NODES-1:0] best_q;
    // class examined this cycle
    class_t               cls;
    logic                 scan;
    logic                 first;

    assign cls   = class_t'(step);
    assign scan  = (phase == PH_ARGMAX);
    assign first = (step == '0);

    ////////////////////////////////
    // running maximum
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (scan) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                if (first || (acc.acc[n][cls] > best_q[n])) begin
                    best_q[n] <= acc.acc[n][cls];
                end
            end
        end
    end

    ////////////////////////////////
    // label register
    ////////////////////////////////
    // y only moves during argmax and holds through done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= '0;
        end else if (scan) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                if (first) begin
                    y.label[n] <= '0;
                end else if (acc.acc[n][cls] > best_q[n]) begin
                    // strict compare, a tie keeps the lower class
                    y.label[n] <= cls;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/gcn_top.sv ====
`default_nettype none

module gcn_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  gcn_bus_pkg::coo_t         coo,
    input  gcn_bus_pkg::feat_col_t    feat_col,
    input  gcn_bus_pkg::wgt_row_t     wgt_row,
    output logic                      rd_en,
    output gcn_dims_pkg::feat_addr_t  rd_addr,
    output gcn_bus_pkg::label_vec_t   y,
    output logic                      done
);

    import gcn_dims_pkg::*;
    import gcn_bus_pkg::*;

    // control
    phase_t    phase;
    step_t     step;
    logic      last;
    logic      load;

    // datapath
    adj_mat_t  adj;
    agg_beat_t beat;
    acc_mat_t  acc;

    // feature index follows the step count during read
    assign rd_addr = feat_addr_t'(step);

    ////////////////////////////////
    // control path
    ////////////////////////////////
    gcn_ctrl_fsm i_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .last  (last),
        .phase (phase),
        .load  (load),
        .rd_en (rd_en),
        .done  (done)
    );

    gcn_step_timer i_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .phase (phase),
        .step  (step),
        .last  (last)
    );

    ////////////////////////////////
    // data path
    ////////////////////////////////
    gcn_adj_builder i_adj (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .coo   (coo),
        .phase (phase),
        .step  (step),
        .adj   (adj)
    );

    gcn_aggregator i_agg (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .feat_col (feat_col),
        .wgt_row  (wgt_row),
        .adj      (adj),
        .beat     (beat)
    );

    gcn_transform_mac i_mac (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .beat  (beat),
        .acc   (acc)
    );

    gcn_argmax i_argmax (
        .clk   (clk),
        .rst_n (rst_n),
        .phase (phase),
        .step  (step),
        .acc   (acc),
        .y     (y)
    );

endmodule

`default_nettype wire

// ==== bench/gcn_clock_gen.sv ====
`default_nettype none

module gcn_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 2;

    // 100 ns period, 50 ns per half
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // released just after the second rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/gcn_assert.sv ====
`default_nettype none

module gcn_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     start,
    input logic                     load,
    input logic                     rd_en,
    input gcn_dims_pkg::feat_addr_t rd_addr,
    input gcn_bus_pkg::label_vec_t  y,
    input logic                     done
);

    timeunit 1ns;
    timeprecision 1ps;

    import gcn_dims_pkg::*;

    // edges from the accepted start to done
    localparam int DONE_LAT = 11 + NUM_FEATS;

    int err_cnt = 0;
    // length of the current read burst
    int rd_run;
    // edges since the last accepted start
    int since_load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_run     <= 0;
            since_load <= 0;
        end else begin
            rd_run <= rd_en ? rd_run + 1 : 0;
            if (load) begin
                since_load <= 0;
            end else if (since_load < 255) begin
                since_load <= since_load + 1;
            end
        end
    end

    //////////////////////////////
    // read burst
    //////////////////////////////
    rd_first: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rd_en) |-> rd_addr == '0)
        else begin $error("read burst does not start at index 0"); err_cnt++; end

    rd_step: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en && $past(rd_en) |-> rd_addr == $past(rd_addr) + feat_addr_t'(1))
        else begin $error("rd_addr does not count up by one"); err_cnt++; end

    rd_max: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> rd_run < NUM_FEATS)
        else begin $error("read burst longer than NUM_FEATS"); err_cnt++; end

    rd_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(rd_en) |-> rd_run == NUM_FEATS)
        else begin $error("read burst shorter than NUM_FEATS"); err_cnt++; end

    //////////////////////////////
    // done and labels
    //////////////////////////////
    done_lat: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> since_load == DONE_LAT)
        else begin $error("done rose at the wrong cycle after start"); err_cnt++; end

    done_hold: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |=> done && $stable(y))
        else begin $error("done or y moved without a new start"); err_cnt++; end

    done_clear: assert property (@(posedge clk) disable iff (!rst_n)
        done && start |=> !done)
        else begin $error("done stayed high after an accepted start"); err_cnt++; end

endmodule

bind gcn_top gcn_assert i_timing_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .load    (load),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .y       (y),
    .done    (done)
);

`default_nettype wire

// ==== bench/gcn_tb.sv ====
`default_nettype none

module gcn_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import gcn_dims_pkg::*;
    import gcn_bus_pkg::*;

    localparam int RESET_WAIT = 10;
    localparam int DONE_WAIT  = 40;

    logic       clk;
    logic       rst_n;
    logic       start;
    coo_t       coo;
    feat_col_t  feat_col;
    wgt_row_t   wgt_row;
    logic       rd_en;
    feat_addr_t rd_addr;
    label_vec_t y;
    logic       done;

    // one column and one weight row per feature index
    feat_col_t  feat_mem [NUM_FEATS];
    wgt_row_t   wgt_mem  [NUM_FEATS];
    label_vec_t exp_y;
    logic       started;
    // read request seen at the last edge
    logic       rd_hit;
    feat_addr_t rd_idx;

    gcn_clock_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    gcn_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .coo      (coo),
        .feat_col (feat_col),
        .wgt_row  (wgt_row),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .y        (y),
        .done     (done)
    );

    //////////////////////////////
    // memory models
    //////////////////////////////
    // both memories answer the cycle after the strobe
    always @(posedge clk) begin
        rd_hit = rd_en;
        rd_idx = rd_addr;
        #1;
        if (rd_hit) begin
            feat_col = feat_mem[rd_idx];
            wgt_row  = wgt_mem[rd_idx];
        end
    end

    task automatic fill_memories(input logic zero_wgt);
        for (int k = 0; k < NUM_FEATS; k++) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                feat_mem[k].feat[n] = feat_t'($urandom());
            end
            for (int c = 0; c < NUM_CLASSES; c++) begin
                wgt_mem[k].wgt[c] = zero_wgt ? '0 : wgt_t'($urandom());
            end
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    // every edge with two real ends is ORed in both directions
    function automatic adj_mat_t neighbour_masks(input coo_t g);
        adj_mat_t a;
        int       s;
        int       d;
        a = '0;
        for (int e = 0; e < NUM_EDGES; e++) begin
            s = int'(g.slot[e].src);
            d = int'(g.slot[e].dst);
            if (s != 0 && d != 0) begin
                a.nbr[s-1][d-1] = 1'b1;
                a.nbr[d-1][s-1] = 1'b1;
            end
        end
        return a;
    endfunction

    // neighbour sum times weight, summed over features, then first-max class
    function automatic label_vec_t expected_labels(input coo_t g);
        adj_mat_t   a;
        int         agg;
        int         best;
        int         acc [NUM_NODES][NUM_CLASSES];
        label_vec_t lab;
        a   = neighbour_masks(g);
        lab = '0;
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                acc[n][c] = 0;
            end
        end
        for (int k = 0; k < NUM_FEATS; k++) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                agg = 0;
                for (int m = 0; m < NUM_NODES; m++) begin
                    if (a.nbr[n][m]) begin
                        agg = agg + int'(feat_mem[k].feat[m]);
                    end
                end
                for (int c = 0; c < NUM_CLASSES; c++) begin
                    acc[n][c] = acc[n][c] + agg * int'(wgt_mem[k].wgt[c]);
                end
            end
        end
        for (int n = 0; n < NUM_NODES; n++) begin
            best = acc[n][0];
            for (int c = 1; c < NUM_CLASSES; c++) begin
                // strictly greater so ties stay on the lower class
                if (acc[n][c] > best) begin
                    best         = acc[n][c];
                    lab.label[n] = class_t'(c);
                end
            end
        end
        return lab;
    endfunction

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////
    function automatic edge_t make_edge(input int s, input int d);
        edge_t e;
        e.src = node_id_t'(s);
        e.dst = node_id_t'(d);
        return e;
    endfunction

    // about a third of the slots left empty
    function automatic coo_t random_graph();
        coo_t g;
        g = '0;
        for (int e = 0; e < NUM_EDGES; e++) begin
            if ($urandom_range(2) != 0) begin
                g.slot[e] = make_edge($urandom_range(NUM_NODES, 1),
                                      $urandom_range(NUM_NODES, 1));
            end
        end
        return g;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic hold_for_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < RESET_WAIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            abort_run();
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < DONE_WAIT) begin
            @(posedge clk);
            n++;
        end
        if (!done) begin
            $display("timeout: done did not rise after start");
            abort_run();
        end
    endtask

    // one pulse on start, then a few cycles parked in done
    task automatic run_graph(input coo_t g);
        @(posedge clk);
        #1;
        coo     = g;
        start   = 1'b1;
        exp_y   = expected_labels(g);
        started = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        // edge list must already be captured
        coo   = random_graph();
        wait_done();
        repeat (4) @(posedge clk);
    endtask

    //////////////////////////////
    // value checks
    //////////////////////////////
    idle_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !done && !rd_en)
        else begin
            $error("FAILED done/rd_en before start: done=%h rd_en=%h", done, rd_en);
            abort_run();
        end

    idle_y: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> y == '0)
        else begin
            $error("FAILED y before start: got %h expected %h", y, 12'h000);
            abort_run();
        end

    // labels checked on every done cycle until the next start
    labels: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |-> y == exp_y)
        else begin
            $error("FAILED y: got %h expected %h", y, exp_y);
            abort_run();
        end

    always @(posedge clk) begin
        if (i_dut.i_timing_chk.err_cnt != 0) begin
            $display("a control timing check in gcn_assert failed");
            abort_run();
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        coo_t g;
        void'($urandom(73));
        start    = 1'b0;
        coo      = '0;
        feat_col = '0;
        wgt_row  = '0;
        exp_y    = '0;
        started  = 1'b0;
        rd_hit   = 1'b0;
        rd_idx   = '0;
        fill_memories(1'b0);
        hold_for_reset();
        // a few idle cycles under the reset checks
        repeat (3) @(posedge clk);

        // random graphs back to back with each start from done
        for (int r = 0; r < 6; r++) begin
            run_graph(random_graph());
        end

        // repeated edge, reversed edge, self loop, half-empty slot
        g         = '0;
        g.slot[0] = make_edge(1, 2);
        g.slot[1] = make_edge(2, 1);
        g.slot[2] = make_edge(1, 2);
        g.slot[3] = make_edge(3, 3);
        g.slot[4] = make_edge(4, 5);
        g.slot[5] = make_edge(6, 0);
        run_graph(g);

        // all sums tie at zero
        fill_memories(1'b1);
        run_graph(random_graph());

        // fresh data and a new graph over the old sums
        fill_memories(1'b0);
        run_graph(random_graph());
        run_graph(g);

        repeat (2) @(posedge clk);
        if (i_dut.i_timing_chk.err_cnt != 0) begin
            abort_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/gcn_dims_pkg.sv
hw/gcn_bus_pkg.sv
hw/gcn_ctrl_fsm.sv
hw/gcn_step_timer.sv
hw/gcn_adj_builder.sv
hw/gcn_aggregator.sv
hw/gcn_transform_mac.sv
hw/gcn_argmax.sv
hw/gcn_top.sv
bench/gcn_clock_gen.sv
bench/gcn_assert.sv
bench/gcn_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the GCN testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module gcn_tb -f flist.f -o gcn_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# error limit raised so the testbench reaches its own verdict line
./obj_dir/gcn_sim +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
